// ==== include/hwcnn_cfg.svh ====
`ifndef HWCNN_CFG_SVH
`define HWCNN_CFG_SVH

//////////////////////////////
// DDR side
`define HWCNN_DDR_ADDR_LEN 32 // Beat address
`define HWCNN_DDR_DATA_LEN 256 // One beat
`define HWCNN_BEATS_LEN 8 // Burst length count

//////////////////////////////
// On-chip buffer rows
`define HWCNN_BB_ADDR_LEN 7 // Bias buffer
`define HWCNN_WB_ADDR_LEN 6 // Weight buffer
`define HWCNN_BP_ADDR_LEN 6 // Feature buffer
`define HWCNN_BUF_ADDR_LEN 7 // Widest row address

//////////////////////////////
// Word widths
`define HWCNN_BIAS_LEN 20
`define HWCNN_WEIGHT_LEN 8
`define HWCNN_FEATURE_LEN 32
`define HWCNN_LANE_LEN 5 // Lane index within a row

`endif

// ==== hdl/hwcnn_pkg.sv ====
`include "hwcnn_cfg.svh"

package hwcnn_pkg;

	// Load opcodes
	typedef enum logic [1:0] {
		nop         = 2'd0,
		load_bias   = 2'd1,
		load_weight = 2'd2,
		load_data   = 2'd3
	} load_op_t;

	typedef struct packed {
		load_op_t                          op;
		logic [`HWCNN_DDR_ADDR_LEN-1:0]    ddr_addr; // First beat in DDR
		logic [`HWCNN_BEATS_LEN-1:0]       beats;
		logic [`HWCNN_BUF_ADDR_LEN-1:0]    buf_addr; // First buffer row
	} inst_t;

	// Decoder to loader
	typedef struct packed {
		logic [`HWCNN_DDR_ADDR_LEN-1:0]    ddr_addr;
		logic [`HWCNN_BEATS_LEN-1:0]       beats;
		logic [`HWCNN_BUF_ADDR_LEN-1:0]    buf_addr;
	} load_cmd_t;

	typedef struct packed {
		logic [`HWCNN_DDR_ADDR_LEN-1:0]    addr;
		logic [`HWCNN_BEATS_LEN-1:0]       beats;
	} ddr_cmd_t;

	// Show-ahead FIFO toward the design
	typedef struct packed {
		logic                              fifo_empty;
		logic [`HWCNN_DDR_DATA_LEN-1:0]    fifo_data;
	} ddr_rd_t;

	typedef logic signed [`HWCNN_BIAS_LEN-1:0]    bias_word_t;
	typedef logic signed [`HWCNN_WEIGHT_LEN-1:0]  weight_word_t;
	typedef logic signed [`HWCNN_FEATURE_LEN-1:0] feature_word_t;

	typedef struct packed {
		logic [`HWCNN_BUF_ADDR_LEN-1:0]    row;
		logic [`HWCNN_LANE_LEN-1:0]        lane;
	} buf_rd_req_t;

endpackage

// ==== hdl/inst_decode.sv ====
`timescale 1ns/10ps

module inst_decode (
	input  logic                  clk,
	input  logic                  reset,
	input  hwcnn_pkg::inst_t      instruct,
	input  logic                  inst_empty,
	input  logic                  bias_idle,
	input  logic                  weight_idle,
	input  logic                  data_idle,
	output logic                  inst_req,
	output hwcnn_pkg::load_cmd_t  load_cmd,
	output logic                  bias_start,
	output logic                  weight_start,
	output logic                  data_start,
	output logic                  busy
);

	hwcnn_pkg::inst_t inst_q; // Held instruction
	logic             held;
	logic             pending; // Fetch issued, word arrives this cycle
	logic             target_idle;
	logic             dispatch;

	//////////////////////////////
	// Fetch

	assign inst_req = !held && !pending && !inst_empty;

	always_ff @(posedge clk) begin
		if (reset) begin
			held    <= 1'b0;
			pending <= 1'b0;
		end else begin
			pending <= inst_req;
			if (pending)
				held <= 1'b1;
			else if (dispatch)
				held <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (pending)
			inst_q <= instruct;
	end

	//////////////////////////////
	// Dispatch

	always_comb begin
		case (inst_q.op)
			hwcnn_pkg::load_bias:   target_idle = bias_idle;
			hwcnn_pkg::load_weight: target_idle = weight_idle;
			hwcnn_pkg::load_data:   target_idle = data_idle;
			default:                target_idle = 1'b1; // Nop just drops out
		endcase
	end

	assign dispatch = held && target_idle;

	assign bias_start   = dispatch && (inst_q.op == hwcnn_pkg::load_bias);
	assign weight_start = dispatch && (inst_q.op == hwcnn_pkg::load_weight);
	assign data_start   = dispatch && (inst_q.op == hwcnn_pkg::load_data);

	assign load_cmd.ddr_addr = inst_q.ddr_addr;
	assign load_cmd.beats    = inst_q.beats;
	assign load_cmd.buf_addr = inst_q.buf_addr;

	assign busy = held || pending || !(bias_idle && weight_idle && data_idle);

endmodule

// ==== hdl/ddr_read_arbiter.sv ====
`timescale 1ns/10ps

module ddr_read_arbiter (
	input  logic                 clk,
	input  logic                 reset,
	input  logic [2:0]           burst_req,
	input  hwcnn_pkg::ddr_cmd_t  burst_cmd [0:2],
	input  hwcnn_pkg::ddr_rd_t   ddr_rd,
	input  logic [2:0]           fifo_req_in,
	output logic [2:0]           grant,
	output logic                 ddr_conf,
	output hwcnn_pkg::ddr_cmd_t  ddr_cmd,
	output logic                 ddr_fifo_req,
	output hwcnn_pkg::ddr_rd_t   loader_rd [0:2]
);

	logic       active; // A burst owns the port
	logic [1:0] owner;
	logic [1:0] ptr; // Highest priority requester
	logic [1:0] pick;
	logic       found;
	logic       conf_q;

	function automatic logic [1:0] next_port(input logic [1:0] p);
		return (p == 2'd2) ? 2'd0 : p + 2'd1;
	endfunction

	// Round-robin search from ptr
	always_comb begin
		logic [1:0] cand;
		cand  = ptr;
		found = 1'b0;
		pick  = ptr;
		for (int k = 0; k < 3; k++) begin
			if (!found && burst_req[cand]) begin
				found = 1'b1;
				pick  = cand;
			end
			cand = next_port(cand);
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			active <= 1'b0;
			owner  <= 2'd0;
			ptr    <= 2'd0; // Bias first
			conf_q <= 1'b0;
		end else begin
			conf_q <= 1'b0;
			if (active) begin
				if (!burst_req[owner]) begin // Last beat popped
					active <= 1'b0;
					ptr    <= next_port(owner);
				end
			end else if (found) begin
				active <= 1'b1;
				owner  <= pick;
				conf_q <= 1'b1;
			end
		end
	end

	assign grant        = active ? (3'b001 << owner) : 3'b000;
	assign ddr_conf     = conf_q;
	assign ddr_cmd      = burst_cmd[owner];
	assign ddr_fifo_req = active && fifo_req_in[owner];

	// Losers see an empty FIFO
	always_comb begin
		for (int i = 0; i < 3; i++) begin
			loader_rd[i].fifo_data  = ddr_rd.fifo_data;
			loader_rd[i].fifo_empty = ddr_rd.fifo_empty || !grant[i];
		end
	end

endmodule

// ==== hdl/burst_loader.sv ====
`timescale 1ns/10ps

`include "hwcnn_cfg.svh"

module burst_loader #(
	parameter type word_t = hwcnn_pkg::bias_word_t,
	parameter int  ROW_LEN = 7,
	localparam int WORD_LEN = $bits(word_t),
	localparam int LANES = `HWCNN_DDR_DATA_LEN / WORD_LEN
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  start,
	input  hwcnn_pkg::load_cmd_t  cmd,
	input  logic                  grant,
	input  hwcnn_pkg::ddr_rd_t    ddr_rd,
	output logic                  burst_req,
	output hwcnn_pkg::ddr_cmd_t   burst_cmd,
	output logic                  fifo_req,
	output logic                  wr_en,
	output logic [ROW_LEN-1:0]    wr_row,
	output word_t [LANES-1:0]     wr_row_data,
	output logic                  idle
);

	hwcnn_pkg::load_cmd_t          cmd_q;
	logic                          active;
	logic [`HWCNN_BEATS_LEN-1:0]   beat_cnt; // Beats popped so far
	logic [`HWCNN_BEATS_LEN-1:0]   row_sum;
	logic                          last_beat;

	//////////////////////////////
	// Burst control

	always_ff @(posedge clk) begin
		if (reset) begin
			active   <= 1'b0;
			beat_cnt <= '0;
		end else if (start) begin
			active   <= 1'b1;
			beat_cnt <= '0;
		end else if (fifo_req) begin
			beat_cnt <= beat_cnt + 1'b1;
			if (last_beat)
				active <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (start)
			cmd_q <= cmd; // Held for the whole burst
	end

	assign last_beat = (beat_cnt == cmd_q.beats - 1'b1);
	assign fifo_req  = active && grant && !ddr_rd.fifo_empty;

	// Drops together with the final pop
	assign burst_req = active && !(fifo_req && last_beat);

	assign burst_cmd.addr  = cmd_q.ddr_addr;
	assign burst_cmd.beats = cmd_q.beats;

	assign idle = !active;

	//////////////////////////////
	// Beat to row

	assign row_sum = `HWCNN_BEATS_LEN'(cmd_q.buf_addr) + beat_cnt;

	assign wr_en  = fifo_req;
	assign wr_row = row_sum[ROW_LEN-1:0];

	always_comb begin
		for (int i = 0; i < LANES; i++)
			wr_row_data[i] = word_t'(ddr_rd.fifo_data[WORD_LEN*i +: WORD_LEN]); // Lane 0 at LSB
	end

endmodule

// ==== hdl/line_buffer.sv ====
`timescale 1ns/10ps

`include "hwcnn_cfg.svh"

module line_buffer #(
	parameter type word_t = hwcnn_pkg::bias_word_t,
	parameter int  ROW_LEN = 7,
	localparam int LANES = `HWCNN_DDR_DATA_LEN / $bits(word_t),
	localparam int DEPTH = 2 ** ROW_LEN
) (
	input  logic                    clk,
	input  logic                    wr_en,
	input  logic [ROW_LEN-1:0]      wr_row,
	input  word_t [LANES-1:0]       wr_row_data,
	input  hwcnn_pkg::buf_rd_req_t  rd,
	output word_t                   q
);

	word_t [LANES-1:0] mem [DEPTH]; // One DDR beat per row

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_row] <= wr_row_data;
	end

	// Lanes past the row end read zero
	always_ff @(posedge clk) begin
		if (rd.lane < LANES)
			q <= mem[rd.row[ROW_LEN-1:0]][rd.lane];
		else
			q <= '0;
	end

endmodule

// ==== hdl/hwcnn_loader_top.sv ====
`timescale 1ns/10ps

`include "hwcnn_cfg.svh"

module hwcnn_loader_top (
	input  logic                           clk,
	input  logic                           reset,
	input  hwcnn_pkg::inst_t               instruct,
	input  logic                           inst_empty,
	input  hwcnn_pkg::ddr_rd_t             ddr_rd,
	input  hwcnn_pkg::buf_rd_req_t         bias_rd,
	input  hwcnn_pkg::buf_rd_req_t         weight_rd,
	input  hwcnn_pkg::buf_rd_req_t         feature_rd,
	output logic                           inst_req,
	output logic                           ddr_conf,
	output hwcnn_pkg::ddr_cmd_t            ddr_cmd,
	output logic                           ddr_fifo_req,
	output hwcnn_pkg::bias_word_t          bias_q,
	output hwcnn_pkg::weight_word_t        weight_q,
	output hwcnn_pkg::feature_word_t       feature_q,
	output logic                           busy
);

	localparam int BIAS_LANES    = `HWCNN_DDR_DATA_LEN / `HWCNN_BIAS_LEN;
	localparam int WEIGHT_LANES  = `HWCNN_DDR_DATA_LEN / `HWCNN_WEIGHT_LEN;
	localparam int FEATURE_LANES = `HWCNN_DDR_DATA_LEN / `HWCNN_FEATURE_LEN;

	hwcnn_pkg::load_cmd_t  load_cmd;
	logic                  bias_start, weight_start, data_start;
	logic                  bias_idle, weight_idle, data_idle;

	// Index 0 bias, 1 weight, 2 feature
	logic [2:0]            burst_req;
	logic [2:0]            grant;
	logic [2:0]            fifo_req;
	hwcnn_pkg::ddr_cmd_t   burst_cmd [0:2];
	hwcnn_pkg::ddr_rd_t    loader_rd [0:2];

	logic [2:0]            wr_en;
	logic [`HWCNN_BB_ADDR_LEN-1:0]                  bias_wr_row;
	logic [`HWCNN_WB_ADDR_LEN-1:0]                  weight_wr_row;
	logic [`HWCNN_BP_ADDR_LEN-1:0]                  feature_wr_row;
	hwcnn_pkg::bias_word_t [BIAS_LANES-1:0]          bias_wr_data;
	hwcnn_pkg::weight_word_t [WEIGHT_LANES-1:0]      weight_wr_data;
	hwcnn_pkg::feature_word_t [FEATURE_LANES-1:0]    feature_wr_data;

	inst_decode u_decode (
		.clk(clk), .reset(reset),
		.instruct(instruct), .inst_empty(inst_empty),
		.bias_idle(bias_idle), .weight_idle(weight_idle), .data_idle(data_idle),
		.inst_req(inst_req), .load_cmd(load_cmd),
		.bias_start(bias_start), .weight_start(weight_start), .data_start(data_start),
		.busy(busy)
	);

	ddr_read_arbiter u_arbiter (
		.clk(clk), .reset(reset),
		.burst_req(burst_req), .burst_cmd(burst_cmd),
		.ddr_rd(ddr_rd), .fifo_req_in(fifo_req),
		.grant(grant), .ddr_conf(ddr_conf), .ddr_cmd(ddr_cmd),
		.ddr_fifo_req(ddr_fifo_req), .loader_rd(loader_rd)
	);

	//////////////////////////////
	// Bias path
	burst_loader #(.word_t(hwcnn_pkg::bias_word_t), .ROW_LEN(`HWCNN_BB_ADDR_LEN)) u_bias_ld (
		.clk(clk), .reset(reset), .start(bias_start), .cmd(load_cmd),
		.grant(grant[0]), .ddr_rd(loader_rd[0]),
		.burst_req(burst_req[0]), .burst_cmd(burst_cmd[0]), .fifo_req(fifo_req[0]),
		.wr_en(wr_en[0]), .wr_row(bias_wr_row), .wr_row_data(bias_wr_data),
		.idle(bias_idle)
	);
	line_buffer #(.word_t(hwcnn_pkg::bias_word_t), .ROW_LEN(`HWCNN_BB_ADDR_LEN)) u_bias_buf (
		.clk(clk), .wr_en(wr_en[0]), .wr_row(bias_wr_row), .wr_row_data(bias_wr_data),
		.rd(bias_rd), .q(bias_q)
	);

	//////////////////////////////
	// Weight path
	burst_loader #(.word_t(hwcnn_pkg::weight_word_t), .ROW_LEN(`HWCNN_WB_ADDR_LEN)) u_weight_ld (
		.clk(clk), .reset(reset), .start(weight_start), .cmd(load_cmd),
		.grant(grant[1]), .ddr_rd(loader_rd[1]),
		.burst_req(burst_req[1]), .burst_cmd(burst_cmd[1]), .fifo_req(fifo_req[1]),
		.wr_en(wr_en[1]), .wr_row(weight_wr_row), .wr_row_data(weight_wr_data),
		.idle(weight_idle)
	);
	line_buffer #(.word_t(hwcnn_pkg::weight_word_t), .ROW_LEN(`HWCNN_WB_ADDR_LEN)) u_weight_buf (
		.clk(clk), .wr_en(wr_en[1]), .wr_row(weight_wr_row), .wr_row_data(weight_wr_data),
		.rd(weight_rd), .q(weight_q)
	);

	//////////////////////////////
	// Feature path
	burst_loader #(.word_t(hwcnn_pkg::feature_word_t), .ROW_LEN(`HWCNN_BP_ADDR_LEN)) u_data_ld (
		.clk(clk), .reset(reset), .start(data_start), .cmd(load_cmd),
		.grant(grant[2]), .ddr_rd(loader_rd[2]),
		.burst_req(burst_req[2]), .burst_cmd(burst_cmd[2]), .fifo_req(fifo_req[2]),
		.wr_en(wr_en[2]), .wr_row(feature_wr_row), .wr_row_data(feature_wr_data),
		.idle(data_idle)
	);
	line_buffer #(.word_t(hwcnn_pkg::feature_word_t), .ROW_LEN(`HWCNN_BP_ADDR_LEN)) u_data_buf (
		.clk(clk), .wr_en(wr_en[2]), .wr_row(feature_wr_row), .wr_row_data(feature_wr_data),
		.rd(feature_rd), .q(feature_q)
	);

endmodule

// ==== bench/clock_gen.sv ====
`timescale 1ns/10ps

module clock_gen #(
	parameter real PERIOD = 8.0,
	parameter int  RESET_CYCLES = 16
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2.0) clk = ~clk;
	end

	// Released on a falling edge
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

endmodule

// ==== bench/ddr_model.sv ====
`timescale 1ns/10ps

`include "hwcnn_cfg.svh"

module ddr_model (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 ddr_conf,
	input  hwcnn_pkg::ddr_cmd_t  ddr_cmd,
	input  logic                 ddr_fifo_req,
	output hwcnn_pkg::ddr_rd_t   ddr_rd,
	output logic                 fault
);

	localparam int DEPTH = 256;

	logic [`HWCNN_DDR_DATA_LEN-1:0] mem [0:DEPTH-1];
	integer     seed;
	logic [7:0] ptr; // Next beat to present
	int         left; // Beats still owed in this burst
	logic       stall;

	initial begin
		seed   = 32'h5e50;
		ptr    = '0;
		left   = 0;
		fault  = 1'b0;
		ddr_rd = '0;
		ddr_rd.fifo_empty = 1'b1;
		for (int i = 0; i < DEPTH; i++) begin
			for (int j = 0; j < `HWCNN_DDR_DATA_LEN / 32; j++)
				mem[i][32*j +: 32] = $random(seed);
		end
	end

	//////////////////////////////
	// Burst bookkeeping
	always @(posedge clk) begin
		if (reset) begin
			left = 0;
		end else begin
			if (ddr_fifo_req) begin
				if (ddr_rd.fifo_empty) begin
					$display("DDR pop while fifo_empty is high at %0t ns", $time);
					fault = 1'b1;
				end else if (left == 0) begin
					$display("DDR pop with no burst open at %0t ns", $time);
					fault = 1'b1;
				end else begin
					ptr  = ptr + 8'd1;
					left = left - 1;
				end
			end
			if (ddr_conf) begin
				if (left != 0) begin
					$display("DDR burst started before the last one drained at %0t ns", $time);
					fault = 1'b1;
				end
				ptr  = ddr_cmd.addr[7:0];
				left = ddr_cmd.beats;
			end
		end
	end

	// Show-ahead data with random stalls
	always @(negedge clk) begin
		stall = (($random(seed) & 3) == 0);
		ddr_rd.fifo_empty = (left == 0) || stall;
		ddr_rd.fifo_data  = mem[ptr];
	end

endmodule

// ==== bench/tb_hwcnn_loader.sv ====
`timescale 1ns/10ps

`include "hwcnn_cfg.svh"

module tb_hwcnn_loader;

	localparam int CASE_SLOTS = 64;

	logic                      clk;
	logic                      reset;
	hwcnn_pkg::inst_t          instruct;
	logic                      inst_empty;
	hwcnn_pkg::ddr_rd_t        ddr_rd;
	hwcnn_pkg::buf_rd_req_t    bias_rd;
	hwcnn_pkg::buf_rd_req_t    weight_rd;
	hwcnn_pkg::buf_rd_req_t    feature_rd;
	logic                      inst_req;
	logic                      ddr_conf;
	hwcnn_pkg::ddr_cmd_t       ddr_cmd;
	logic                      ddr_fifo_req;
	hwcnn_pkg::bias_word_t     bias_q;
	hwcnn_pkg::weight_word_t   weight_q;
	hwcnn_pkg::feature_word_t  feature_q;
	logic                      busy;
	logic                      ddr_fault;

	logic [63:0]               cases [0:CASE_SLOTS-1];
	hwcnn_pkg::inst_t          inst_fifo [$]; // Instruction FIFO contents
	hwcnn_pkg::ddr_cmd_t       conf_fifo [$]; // Bursts not yet configured
	logic [63:0]               check_list [$];
	hwcnn_pkg::inst_t          fetched;
	logic                      fifo_open;
	int                        beats_total;
	int                        limit_cycles;
	int                        conf_count;

	clock_gen #(.PERIOD(8.0), .RESET_CYCLES(16)) u_clk (.clk(clk), .reset(reset));

	ddr_model u_ddr (
		.clk(clk), .reset(reset), .ddr_conf(ddr_conf), .ddr_cmd(ddr_cmd),
		.ddr_fifo_req(ddr_fifo_req), .ddr_rd(ddr_rd), .fault(ddr_fault)
	);

	hwcnn_loader_top u_dut (
		.clk(clk), .reset(reset), .instruct(instruct), .inst_empty(inst_empty),
		.ddr_rd(ddr_rd), .bias_rd(bias_rd), .weight_rd(weight_rd), .feature_rd(feature_rd),
		.inst_req(inst_req), .ddr_conf(ddr_conf), .ddr_cmd(ddr_cmd),
		.ddr_fifo_req(ddr_fifo_req), .bias_q(bias_q), .weight_q(weight_q),
		.feature_q(feature_q), .busy(busy)
	);

	//////////////////////////////
	// Failure and compare tasks
	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic check_level(input string name, input logic exp, input logic act);
		if (act !== exp)
			fail_run($sformatf("Mismatch at %0t ns: %s expected %b got %b", $time, name, exp, act));
	endtask

	task automatic check_ddr_cmd(input hwcnn_pkg::ddr_cmd_t exp, input hwcnn_pkg::ddr_cmd_t act);
		if (act !== exp)
			fail_run($sformatf("Mismatch at %0t ns: ddr_cmd expected %h got %h", $time, exp, act));
	endtask

	task automatic check_bias(input string name, input hwcnn_pkg::bias_word_t exp,
			input hwcnn_pkg::bias_word_t act);
		if (act !== exp)
			fail_run($sformatf("Mismatch at %0t ns: %s expected %h got %h", $time, name, exp, act));
	endtask

	task automatic check_weight(input string name, input hwcnn_pkg::weight_word_t exp,
			input hwcnn_pkg::weight_word_t act);
		if (act !== exp)
			fail_run($sformatf("Mismatch at %0t ns: %s expected %h got %h", $time, name, exp, act));
	endtask

	task automatic check_feature(input string name, input hwcnn_pkg::feature_word_t exp,
			input hwcnn_pkg::feature_word_t act);
		if (act !== exp)
			fail_run($sformatf("Mismatch at %0t ns: %s expected %h got %h", $time, name, exp, act));
	endtask

	//////////////////////////////
	// Instruction FIFO model
	always @(posedge clk) begin
		if (!reset && inst_req) begin
			if (inst_empty || inst_fifo.size() == 0)
				fail_run("inst_req was raised while the instruction FIFO was empty");
			else
				fetched = inst_fifo.pop_front();
		end
	end

	always @(negedge clk) begin
		instruct   = fetched; // Word shows up the cycle after the pulse
		inst_empty = !fifo_open || (inst_fifo.size() == 0);
	end

	// Each burst matches one outstanding load
	// The first three follow program order
	always @(posedge clk) begin
		int idx;
		idx = 0;
		if (!reset && ddr_conf) begin
			if (conf_count >= 3) begin
				for (int k = conf_fifo.size() - 1; k >= 0; k--) begin
					if (conf_fifo[k] == ddr_cmd)
						idx = k;
				end
			end
			if (conf_fifo.size() == 0) begin
				fail_run("ddr_conf was pulsed with no load outstanding");
			end else begin
				check_ddr_cmd(conf_fifo[idx], ddr_cmd);
				conf_fifo.delete(idx);
				conf_count++;
			end
		end
	end

	always @(negedge clk) begin
		if (ddr_fault)
			fail_run("The DDR model saw a protocol error");
	end

	// Watchdog
	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk);
		fail_run($sformatf("Timeout after %0d cycles with the loads unfinished", limit_cycles));
	end

	//////////////////////////////
	// Case file and read-back
	task automatic load_cases();
		hwcnn_pkg::inst_t    inst;
		hwcnn_pkg::ddr_cmd_t cmd;
		int                  n;
		for (int i = 0; i < CASE_SLOTS; i++)
			cases[i] = '0;
		$readmemh("bench/loader_cases.txt", cases);
		n = 0;
		while (n < CASE_SLOTS && (cases[n][63:60] == 4'h1 || cases[n][63:60] == 4'h2)) begin
			if (cases[n][63:60] == 4'h1) begin
				inst.op       = hwcnn_pkg::load_op_t'(cases[n][57:56]);
				inst.ddr_addr = cases[n][55:24];
				inst.beats    = cases[n][23:16];
				inst.buf_addr = cases[n][14:8];
				inst_fifo.push_back(inst);
				if (inst.op != hwcnn_pkg::nop) begin
					cmd.addr  = inst.ddr_addr;
					cmd.beats = inst.beats;
					conf_fifo.push_back(cmd);
					beats_total += inst.beats;
				end
			end else begin
				check_list.push_back(cases[n]);
			end
			n++;
		end
	endtask

	task automatic read_back(input logic [63:0] rec);
		logic [`HWCNN_DDR_DATA_LEN-1:0] beat;
		hwcnn_pkg::buf_rd_req_t         req;
		string                          where;
		req.row  = rec[22:16];
		req.lane = rec[12:8];
		beat     = u_ddr.mem[rec[31:24]]; // Beat the row should hold
		where    = $sformatf("row %0d lane %0d", req.row, req.lane);
		@(negedge clk);
		bias_rd    = req;
		weight_rd  = req;
		feature_rd = req;
		@(posedge clk);
		@(negedge clk); // One cycle read latency
		case (rec[57:56])
			2'd0: check_bias({"bias_q ", where}, hwcnn_pkg::bias_word_t'(
				beat[`HWCNN_BIAS_LEN*req.lane +: `HWCNN_BIAS_LEN]), bias_q);
			2'd1: check_weight({"weight_q ", where}, hwcnn_pkg::weight_word_t'(
				beat[`HWCNN_WEIGHT_LEN*req.lane +: `HWCNN_WEIGHT_LEN]), weight_q);
			2'd2: check_feature({"feature_q ", where}, hwcnn_pkg::feature_word_t'(
				beat[`HWCNN_FEATURE_LEN*req.lane +: `HWCNN_FEATURE_LEN]), feature_q);
			default: fail_run("A read-back line names an unknown buffer");
		endcase
	endtask

	task automatic run_all();
		wait (!reset);
		repeat (10) begin // FIFO still empty here
			@(posedge clk);
			check_level("inst_req", 1'b0, inst_req);
			check_level("ddr_conf", 1'b0, ddr_conf);
			check_level("ddr_fifo_req", 1'b0, ddr_fifo_req);
			check_level("busy", 1'b0, busy);
		end
		@(posedge clk);
		fifo_open = 1'b1;
		do
			@(negedge clk);
		while (inst_fifo.size() != 0 || busy);
		foreach (check_list[i])
			read_back(check_list[i]);
		if (conf_fifo.size() != 0) begin
			fail_run($sformatf("%0d loads never produced a ddr_conf", conf_fifo.size()));
		end else begin
			$display("Everything OK");
			$finish;
		end
	endtask

	initial begin
		instruct     = '0;
		inst_empty   = 1'b1;
		bias_rd      = '0;
		weight_rd    = '0;
		feature_rd   = '0;
		fetched      = '0;
		fifo_open    = 1'b0;
		beats_total  = 0;
		limit_cycles = 0;
		conf_count   = 0;
		load_cases();
		if (inst_fifo.size() == 0 || check_list.size() == 0) begin
			fail_run("No usable lines were read from bench/loader_cases.txt");
		end else begin
			limit_cycles = 100 * beats_total + 1000;
			run_all();
		end
	end

endmodule

// ==== bench/loader_cases.txt ====
// kind 1 load: 1_op_ddraddr_beats_bufaddr_00 (op 0 nop, 1 bias, 2 weight, 3 feature)
// kind 2 read-back: 2_buf_beataddr_row_lane_00 (buf 0 bias, 1 weight, 2 feature)
1_1_00000010_04_00_00 // Bias rows 0 to 3
1_2_00000040_03_05_00 // Weight rows 5 to 7
1_3_00000080_02_3c_00 // Feature rows 60 and 61
1_0_00000000_00_00_00 // Nop, dropped
1_1_00000020_02_02_00 // Bias rows 2 and 3 again
1_2_000000c0_01_3f_00 // Last weight row
1_3_000000f0_04_0a_00
1_1_00000060_03_7d_00 // Top bias rows
// Bias, rows 2 and 3 hold the later load
2_0_00000010_00_00_00
2_0_00000011_01_0b_00
2_0_00000020_02_05_00
2_0_00000021_03_0b_00
2_0_00000060_7d_00_00
2_0_00000062_7f_0b_00
// Weight
2_1_00000040_05_00_00
2_1_00000041_06_1f_00
2_1_00000042_07_10_00
2_1_000000c0_3f_1f_00
// Feature
2_2_00000080_3c_00_00
2_2_00000081_3d_07_00
2_2_000000f0_0a_03_00
2_2_000000f3_0d_07_00

// ==== compile.f ====
+incdir+include
hdl/hwcnn_pkg.sv
hdl/inst_decode.sv
hdl/ddr_read_arbiter.sv
hdl/burst_loader.sv
hdl/line_buffer.sv
hdl/hwcnn_loader_top.sv
bench/clock_gen.sv
bench/ddr_model.sv
bench/tb_hwcnn_loader.sv
